//--- rtl/ace_macros.svh
`ifndef ACE_MACROS_SVH
`define ACE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Line buffer geometry
//////////////////////////////////////////////////////////////////////

// Pixels in one PAL line, one buffer word each
`define ACE_LINE_PIXELS 208

// Address width of one buffer half
`define ACE_LINE_ADDR_W 8

//////////////////////////////////////////////////////////////////////
// Sync and PS/2 timing, in clk65 cycles
//////////////////////////////////////////////////////////////////////

`define VGA_HSYNC_LEN 16   // VGA hsync pulse at the start of each replay

`define PS2_TIMEOUT 4095   // Idle time before a partial frame is dropped
`define PS2_TIMER_W 12     // Idle counter width, holds PS2_TIMEOUT

// Reset extension after rst_n or Ctrl+Alt+Del
`define POR_CYCLES 8

`endif

//--- rtl/ace_pkg.sv
`default_nettype none

package ace_pkg;

    // One pixel, 3 bits per channel
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
    } rgb3_t;

    // Core video output at PAL rate
    typedef struct packed {
        logic video;      // 1 = white
        logic hsync_n;
        logic vsync_n;
    } pal_video_t;

    // Colour plus syncs, used both before and after the scan doubler
    typedef struct packed {
        rgb3_t rgb;
        logic  hsync_n;
        logic  vsync_n;
    } vga_video_t;

    // 8 rows of 5 keys, 1 = pressed
    typedef logic [7:0][4:0] key_matrix_t;

    // Matrix position of a scan code
    typedef struct packed {
        logic       hit;  // Code maps to a matrix key
        logic [2:0] row;
        logic [2:0] col;
    } key_loc_t;

endpackage

`default_nettype wire

//--- rtl/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "ace_macros.svh"

module ps2_receiver (
    input  wire        clk65,
    input  wire        rst_n,
    input  wire        clkps2,
    input  wire        dataps2,
    output logic       ps2_strobe,
    output logic [7:0] ps2_byte
);

    localparam logic [`PS2_TIMER_W-1:0] IDLE_MAX = `PS2_TIMEOUT;

    logic [1:0]              clk_sync;   // PS/2 clock synchronizer
    logic [1:0]              data_sync;  // PS/2 data synchronizer
    logic                    clk_prev;   // Last synchronized clock level
    logic                    fall;
    logic [10:0]             shift;      // Bits arrive LSB first, shift in at the top
    logic [10:0]             frame;
    logic [3:0]              bit_cnt;    // 0..10 within a frame
    logic [`PS2_TIMER_W-1:0] idle_cnt;
    logic                    frame_ok;

    // Sampling point
    assign fall = clk_prev & ~clk_sync[1];

    // Shift register contents once the current bit is in
    assign frame = {data_sync[1], shift[10:1]};

    // Start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    //////////////////////////////////////////////////////////////////////
    // Line synchronizers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;  // Idle bus is high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], clkps2};
            data_sync <= {data_sync[0], dataps2};
            clk_prev  <= clk_sync[1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bit counter, idle timeout and strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            ps2_strobe <= 1'b0;
        end else begin
            ps2_strobe <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin  // Stop bit
                    bit_cnt    <= '0;
                    ps2_strobe <= frame_ok;  // Bad frames vanish silently
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (idle_cnt == IDLE_MAX) begin
                bit_cnt <= '0;               // Stale partial frame
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // Frame data path
    always_ff @(posedge clk65) begin
        if (fall) begin
            shift <= frame;
        end
        if (fall && bit_cnt == 4'd10) begin
            ps2_byte <= frame[8:1];  // Data bits between start and parity
        end
    end

endmodule

`default_nettype wire

//--- rtl/ace_keyboard.sv
`timescale 1ns/1ps
`default_nettype none

module ace_keyboard (
    input  wire        clk65,
    input  wire        rst_n,
    input  wire        ps2_strobe,
    input  wire  [7:0] ps2_byte,
    input  wire  [7:0] rows,         // Active low row select
    output logic [4:0] columns,      // Active low key sense
    output logic       kbd_reset_n
);

    // Set-2 codes with special meaning
    localparam logic [7:0] CODE_RELEASE  = 8'hF0;
    localparam logic [7:0] CODE_EXTENDED = 8'hE0;
    localparam logic [7:0] CODE_DELETE   = 8'h71;  // After E0
    localparam logic [7:0] CODE_CTRL     = 8'h14;
    localparam logic [7:0] CODE_ALT      = 8'h11;

    logic                 release_armed;
    logic                 extended_armed;
    ace_pkg::key_matrix_t matrix;
    logic                 ctrl_held;
    logic                 alt_held;
    logic                 del_held;
    ace_pkg::key_loc_t    loc;
    logic [4:0]           col_hit;

    //////////////////////////////////////////////////////////////////////
    // Scan code to matrix position
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        loc = '0;
        case (ps2_byte)
            8'h12:   loc = {1'b1, 3'd0, 3'd0};  // Left shift
            8'h59:   loc = {1'b1, 3'd0, 3'd0};  // Right shift
            8'h1A:   loc = {1'b1, 3'd0, 3'd1};  // Z
            8'h22:   loc = {1'b1, 3'd0, 3'd2};  // X
            8'h21:   loc = {1'b1, 3'd0, 3'd3};  // C
            8'h2A:   loc = {1'b1, 3'd0, 3'd4};  // V
            8'h1C:   loc = {1'b1, 3'd1, 3'd0};  // A
            8'h1B:   loc = {1'b1, 3'd1, 3'd1};
            8'h23:   loc = {1'b1, 3'd1, 3'd2};
            8'h2B:   loc = {1'b1, 3'd1, 3'd3};
            8'h34:   loc = {1'b1, 3'd1, 3'd4};  // G
            8'h15:   loc = {1'b1, 3'd2, 3'd0};  // Q
            8'h1D:   loc = {1'b1, 3'd2, 3'd1};
            8'h24:   loc = {1'b1, 3'd2, 3'd2};
            8'h2D:   loc = {1'b1, 3'd2, 3'd3};
            8'h2C:   loc = {1'b1, 3'd2, 3'd4};  // T
            8'h16:   loc = {1'b1, 3'd3, 3'd0};  // 1
            8'h1E:   loc = {1'b1, 3'd3, 3'd1};
            8'h26:   loc = {1'b1, 3'd3, 3'd2};
            8'h25:   loc = {1'b1, 3'd3, 3'd3};
            8'h2E:   loc = {1'b1, 3'd3, 3'd4};  // 5
            8'h45:   loc = {1'b1, 3'd4, 3'd0};  // 0, row runs backwards
            8'h46:   loc = {1'b1, 3'd4, 3'd1};
            8'h3E:   loc = {1'b1, 3'd4, 3'd2};
            8'h3D:   loc = {1'b1, 3'd4, 3'd3};
            8'h36:   loc = {1'b1, 3'd4, 3'd4};  // 6
            8'h4D:   loc = {1'b1, 3'd5, 3'd0};  // P
            8'h44:   loc = {1'b1, 3'd5, 3'd1};
            8'h43:   loc = {1'b1, 3'd5, 3'd2};
            8'h3C:   loc = {1'b1, 3'd5, 3'd3};
            8'h35:   loc = {1'b1, 3'd5, 3'd4};  // Y
            8'h5A:   loc = {1'b1, 3'd6, 3'd0};  // Enter
            8'h4B:   loc = {1'b1, 3'd6, 3'd1};
            8'h42:   loc = {1'b1, 3'd6, 3'd2};
            8'h3B:   loc = {1'b1, 3'd6, 3'd3};
            8'h33:   loc = {1'b1, 3'd6, 3'd4};  // H
            8'h29:   loc = {1'b1, 3'd7, 3'd0};  // Space
            8'h14:   loc = {1'b1, 3'd7, 3'd1};  // Ctrl as symbol shift
            8'h3A:   loc = {1'b1, 3'd7, 3'd2};  // M
            8'h31:   loc = {1'b1, 3'd7, 3'd3};
            8'h32:   loc = {1'b1, 3'd7, 3'd4};  // B
            default: loc = '0;                  // Not an ACE key
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Prefix flags, matrix and reset keys
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            release_armed  <= 1'b0;
            extended_armed <= 1'b0;
            matrix         <= '0;
            ctrl_held      <= 1'b0;
            alt_held       <= 1'b0;
            del_held       <= 1'b0;
        end else if (ps2_strobe) begin
            if (ps2_byte == CODE_RELEASE) begin
                release_armed <= 1'b1;
            end else if (ps2_byte == CODE_EXTENDED) begin
                extended_armed <= 1'b1;
            end else begin
                release_armed  <= 1'b0;  // Code consumes both prefixes
                extended_armed <= 1'b0;
                if (extended_armed) begin
                    if (ps2_byte == CODE_DELETE) begin
                        del_held <= ~release_armed;
                    end
                end else begin
                    if (loc.hit) begin
                        matrix[loc.row][loc.col] <= ~release_armed;
                    end
                    if (ps2_byte == CODE_CTRL) begin
                        ctrl_held <= ~release_armed;
                    end
                    if (ps2_byte == CODE_ALT) begin
                        alt_held <= ~release_armed;
                    end
                end
            end
        end
    end

    // Pressed keys on any selected row, i.e. an AND over active low rows
    always_comb begin
        col_hit = '0;
        for (int r = 0; r < 8; r++) begin
            if (!rows[r]) begin
                col_hit = col_hit | matrix[r];
            end
        end
    end

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            columns <= '1;           // Nothing pressed
        end else begin
            columns <= ~col_hit;
        end
    end

    assign kbd_reset_n = ~(ctrl_held & alt_held & del_held);  // Ctrl+Alt+Del

endmodule

`default_nettype wire

//--- rtl/scan_doubler.sv
`timescale 1ns/1ps
`default_nettype none

`include "ace_macros.svh"

module scan_doubler (
    input  wire                      clk65,
    input  wire                      rst_n,
    input  wire                      pixel_ce,  // Half rate pixel enable
    input  wire ace_pkg::vga_video_t pal_rgb,   // Colour with PAL syncs
    output ace_pkg::vga_video_t      vga
);

    localparam int                          AW        = `ACE_LINE_ADDR_W;
    localparam int                          BUF_DEPTH = 2 << AW;  // Two line halves
    localparam int                          HT_W      = $clog2(`VGA_HSYNC_LEN + 1);
    localparam logic [AW-1:0]               RD_LAST   = AW'(`ACE_LINE_PIXELS - 1);
    localparam logic [HT_W-1:0]             HS_LEN    = HT_W'(`VGA_HSYNC_LEN);

    ace_pkg::rgb3_t  line_buf [BUF_DEPTH];

    // Write side, PAL rate
    logic            bank;       // Half being written
    logic [AW-1:0]   wr_addr;
    logic            hs_prev;    // hsync_n at the last pixel
    logic            vs_line;    // vsync_n latched per line
    logic            line_start;
    logic            wr_bank;
    logic [AW-1:0]   wr_idx;

    // Read side, clk65 rate
    logic [AW-1:0]   rd_cnt;     // Position within a replay
    logic [HT_W-1:0] hs_timer;   // Remaining hsync pulse cycles
    ace_pkg::rgb3_t  rd_pixel;
    logic            blank_d1;   // Pulse state aligned to rd_pixel

    // hsync_n falling on a pixel
    assign line_start = pixel_ce & hs_prev & ~pal_rgb.hsync_n;

    // First pixel of a new line goes to address 0 of the other half
    assign wr_bank = line_start ? ~bank : bank;
    assign wr_idx  = line_start ? '0 : wr_addr;

    //////////////////////////////////////////////////////////////////////
    // Input line capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            bank    <= 1'b0;
            wr_addr <= '0;
            hs_prev <= 1'b1;
            vs_line <= 1'b1;
        end else if (pixel_ce) begin
            hs_prev <= pal_rgb.hsync_n;
            if (line_start) begin
                bank    <= ~bank;             // Swap halves
                wr_addr <= AW'(1);
                vs_line <= pal_rgb.vsync_n;
            end else if (wr_addr != '1) begin
                wr_addr <= wr_addr + 1'b1;    // Overlong lines pile up on the last word
            end
        end
    end

    always_ff @(posedge clk65) begin
        if (pixel_ce) begin
            line_buf[{wr_bank, wr_idx}] <= pal_rgb.rgb;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Replay at double rate
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            rd_cnt   <= '0;
            hs_timer <= '0;
        end else if (line_start || rd_cnt == RD_LAST) begin
            rd_cnt   <= '0;       // Replay starts, twice per input line
            hs_timer <= HS_LEN;
        end else begin
            rd_cnt <= rd_cnt + 1'b1;
            if (hs_timer != '0) begin
                hs_timer <= hs_timer - 1'b1;
            end
        end
    end

    // Buffer read, stage 1
    always_ff @(posedge clk65) begin
        rd_pixel <= line_buf[{~bank, rd_cnt}];  // Previous line
    end

    // Output register, stage 2
    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            blank_d1    <= 1'b0;
            vga.rgb     <= '0;
            vga.hsync_n <= 1'b1;
            vga.vsync_n <= 1'b1;
        end else begin
            blank_d1    <= (hs_timer != '0);
            vga.rgb     <= blank_d1 ? '0 : rd_pixel;  // Black under the pulse
            vga.hsync_n <= ~blank_d1;
            vga.vsync_n <= vs_line;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ace_board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ace_macros.svh"

module ace_board_top (
    input  wire                      clk65,
    input  wire                      rst_n,
    input  wire                      clkps2,
    input  wire                      dataps2,
    input  wire                      ear,
    input  wire ace_pkg::pal_video_t core_video,
    input  wire [7:0]                core_rows,
    input  wire                      core_mic,
    input  wire                      core_spk,
    output logic [4:0]               core_columns,
    output logic                     core_ear,
    output logic                     core_reset_n,
    output logic                     pixel_ce,
    output ace_pkg::vga_video_t      vga,
    output logic                     audio_left,
    output logic                     audio_right
);

    logic                   ps2_strobe;
    logic [7:0]             ps2_byte;
    logic                   kbd_reset_n;
    logic [`POR_CYCLES-1:0] por_sr;   // Fills with ones after reset
    ace_pkg::vga_video_t    pal_rgb;  // Core video as colour

    // Reset extension, restarted by rst_n or Ctrl+Alt+Del
    always_ff @(posedge clk65) begin
        if (!rst_n || !kbd_reset_n) begin
            por_sr <= '0;
        end else begin
            por_sr <= {por_sr[`POR_CYCLES-2:0], 1'b1};
        end
    end

    assign core_reset_n = por_sr[`POR_CYCLES-1];

    // Core pixel rate is half of clk65
    always_ff @(posedge clk65) begin
        if (!rst_n) begin
            pixel_ce <= 1'b0;
        end else begin
            pixel_ce <= ~pixel_ce;
        end
    end

    // B/W to grey, 6 of 7 per channel
    always_comb begin
        pal_rgb.rgb.r   = core_video.video ? 3'd6 : 3'd0;
        pal_rgb.rgb.g   = core_video.video ? 3'd6 : 3'd0;
        pal_rgb.rgb.b   = core_video.video ? 3'd6 : 3'd0;
        pal_rgb.hsync_n = core_video.hsync_n;
        pal_rgb.vsync_n = core_video.vsync_n;
    end

    assign audio_left  = core_spk;
    assign audio_right = core_mic;
    assign core_ear    = ear;       // Tape input straight to the core

    ps2_receiver ps2_i (
        .clk65(clk65), .rst_n(rst_n), .clkps2(clkps2), .dataps2(dataps2),
        .ps2_strobe(ps2_strobe), .ps2_byte(ps2_byte)
    );

    ace_keyboard kbd_i (
        .clk65(clk65), .rst_n(rst_n), .ps2_strobe(ps2_strobe), .ps2_byte(ps2_byte),
        .rows(core_rows), .columns(core_columns), .kbd_reset_n(kbd_reset_n)
    );

    scan_doubler sd_i (
        .clk65(clk65), .rst_n(rst_n), .pixel_ce(pixel_ce), .pal_rgb(pal_rgb), .vga(vga)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ace_board.sv
`timescale 1ns/1ps
`default_nettype none

`include "ace_macros.svh"

module tb_ace_board;

    localparam int HALF_BIT  = 100;                // PS/2 half period in clk65 cycles
    localparam int VID_LINES = 6;
    localparam int LINE_PX   = `ACE_LINE_PIXELS;

    // Set-2 codes by matrix position at index row * 5 + column
    localparam logic [7:0] KEY_CODE [40] = '{
        8'h12, 8'h1A, 8'h22, 8'h21, 8'h2A,  // Shift Z X C V
        8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34,  // A S D F G
        8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C,  // Q W E R T
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,  // 1 to 5
        8'h45, 8'h46, 8'h3E, 8'h3D, 8'h36,  // 0 9 8 7 6
        8'h4D, 8'h44, 8'h43, 8'h3C, 8'h35,  // P O I U Y
        8'h5A, 8'h4B, 8'h42, 8'h3B, 8'h33,  // Enter L K J H
        8'h29, 8'h14, 8'h3A, 8'h31, 8'h32   // Space Ctrl M N B
    };

    logic                 clk65 = 1'b0;
    logic                 rst_n;
    logic                 clkps2;
    logic                 dataps2;
    logic                 ear;
    ace_pkg::pal_video_t  core_video;
    logic [7:0]           core_rows;
    logic                 core_mic;
    logic                 core_spk;
    logic [4:0]           core_columns;
    logic                 core_ear;
    logic                 core_reset_n;
    logic                 pixel_ce;
    ace_pkg::vga_video_t  vga;
    logic                 audio_left;
    logic                 audio_right;

    ace_pkg::key_matrix_t model_keys;  // Keys the model holds pressed
    logic                 model_rel;
    logic                 model_ext;
    logic                 line_px [VID_LINES][LINE_PX];
    logic                 line_vs [VID_LINES];
    int                   line_idx;    // Line whose pixel 0 has been driven

    always #10 clk65 = ~clk65;

    ace_board_top dut_i (
        .clk65(clk65), .rst_n(rst_n), .clkps2(clkps2), .dataps2(dataps2), .ear(ear),
        .core_video(core_video), .core_rows(core_rows), .core_mic(core_mic),
        .core_spk(core_spk), .core_columns(core_columns), .core_ear(core_ear),
        .core_reset_n(core_reset_n), .pixel_ce(pixel_ce), .vga(vga),
        .audio_left(audio_left), .audio_right(audio_right)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int key_index(input logic [7:0] code);
        if (code == 8'h59) return 0;  // Right shift is the same key as left
        for (int i = 0; i < 40; i++) begin
            if (KEY_CODE[i] == code) return i;
        end
        return -1;
    endfunction

    function automatic void apply_to_model(input logic [7:0] code);
        int idx;
        idx = key_index(code);
        if (code == 8'hF0) begin
            model_rel = 1'b1;
        end else if (code == 8'hE0) begin
            model_ext = 1'b1;
        end else begin
            if (!model_ext && idx >= 0) begin
                model_keys[idx / 5][idx % 5] = ~model_rel;  // Extended codes never reach the matrix
            end
            model_rel = 1'b0;
            model_ext = 1'b0;
        end
    endfunction

    // Active low sense over all selected rows
    function automatic logic [4:0] expected_columns(input logic [7:0] rows,
                                                    input ace_pkg::key_matrix_t keys);
        logic [4:0] pressed;
        pressed = '0;
        for (int r = 0; r < 8; r++) begin
            if (rows[r] == 1'b0) pressed = pressed | keys[r];
        end
        return ~pressed;
    endfunction

    function automatic ace_pkg::rgb3_t expected_rgb(input logic video);
        ace_pkg::rgb3_t c;
        c.r = video ? 3'd6 : 3'd0;  // Grey level 6 of 7
        c.g = video ? 3'd6 : 3'd0;
        c.b = video ? 3'd6 : 3'd0;
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and timing helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_columns(input string name, input logic [4:0] got,
                                 input logic [4:0] exp);
        if (got !== exp) stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_rgb(input string name, input ace_pkg::rgb3_t got,
                             input ace_pkg::rgb3_t exp);
        if (got !== exp) stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic drive_step();
        @(posedge clk65);
        #2;                           // Inputs change here
    endtask

    task automatic sample_step();
        @(posedge clk65);
        #1;                           // Outputs settled and inputs not yet moved
    endtask

    //////////////////////////////////////////////////////////////////////
    // PS/2 keyboard side
    //////////////////////////////////////////////////////////////////////

    // Ends on the stop bit edge with the clock still low
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        int          wait_cnt;
        frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};  // Stop, parity, data, start
        drive_step();
        for (int i = 0; i < 10; i++) begin
            dataps2 = frame[i];
            repeat (HALF_BIT) drive_step();
            clkps2 = 1'b0;
            repeat (HALF_BIT) drive_step();
            clkps2 = 1'b1;
        end
        dataps2 = frame[10];
        repeat (HALF_BIT) drive_step();
        clkps2   = 1'b0;
        wait_cnt = 0;
        while (dut_i.ps2_strobe !== 1'b1 && wait_cnt < 10) begin
            drive_step();
            wait_cnt++;
        end
        if (bad_parity) begin
            if (wait_cnt < 10) stop_run("Keyboard byte strobed for a frame with bad parity");
        end else if (wait_cnt == 10) begin
            stop_run("No keyboard byte strobe after a good frame");
        end else if (wait_cnt != 3) begin
            stop_run($sformatf("Keyboard strobe came %0d cycles after the stop bit", wait_cnt));
        end
    endtask

    task automatic finish_frame();
        repeat (HALF_BIT) drive_step();
        clkps2  = 1'b1;               // Bus back to idle
        dataps2 = 1'b1;
        repeat (HALF_BIT) drive_step();
    endtask

    task automatic send_byte(input logic [7:0] code);
        send_frame(code, 1'b0);
        finish_frame();
        apply_to_model(code);
    endtask

    // Every single and multiple row selection
    task automatic sweep_rows();
        for (int v = 0; v < 256; v++) begin
            drive_step();
            core_rows = 8'(v);
            sample_step();
            sample_step();
            check_columns("core_columns", core_columns,
                          expected_columns(core_rows, model_keys));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Video side
    //////////////////////////////////////////////////////////////////////

    task automatic drive_video();
        int t;
        for (int n = 0; n < VID_LINES; n++) begin
            for (int k = 0; k < LINE_PX; k++) begin
                drive_step();
                t = 1;
                while (pixel_ce !== 1'b1) begin
                    if (t == 4) stop_run("pixel_ce stopped toggling");
                    drive_step();
                    t++;
                end
                core_video.video   = line_px[n][k];
                core_video.hsync_n = (k >= 8);      // Sync on the first 8 pixels
                core_video.vsync_n = line_vs[n];
                if (k == 0) line_idx = n;
            end
        end
    endtask

    task automatic wait_hsync_fall();
        logic prev;
        int   t;
        prev = vga.hsync_n;
        t    = 0;
        sample_step();
        while (!(prev === 1'b1 && vga.hsync_n === 1'b0)) begin
            if (t == 2 * LINE_PX) stop_run("No falling edge on the VGA hsync");
            prev = vga.hsync_n;
            sample_step();
            t++;
        end
    endtask

    // Replays after line n's start carry line n - 1
    task automatic check_video();
        int t;
        for (int n = 1; n < VID_LINES; n++) begin
            t = 0;
            while (line_idx < n) begin
                if (t == 4 * LINE_PX) stop_run("Video input line never started");
                sample_step();
                t++;
            end
            for (int rep = 0; rep < 2; rep++) begin
                wait_hsync_fall();
                check_level("vga.vsync_n", vga.vsync_n, line_vs[n]);
                for (int k = 0; k < LINE_PX; k++) begin
                    if (k > 0) sample_step();
                    if (k < `VGA_HSYNC_LEN) begin
                        check_level("vga.hsync_n", vga.hsync_n, 1'b0);
                        check_rgb("vga.rgb", vga.rgb, '0);
                    end else begin
                        check_level("vga.hsync_n", vga.hsync_n, 1'b1);
                        check_rgb("vga.rgb", vga.rgb, expected_rgb(line_px[n - 1][k]));
                    end
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int t;
        int idx;
        void'($urandom(32'he4a5_abee));
        line_idx   = -1;
        model_keys = '0;
        model_rel  = 1'b0;
        model_ext  = 1'b0;
        rst_n      = 1'b0;
        clkps2     = 1'b1;
        dataps2    = 1'b1;
        ear        = 1'b0;
        core_video.video   = 1'b0;
        core_video.hsync_n = 1'b1;
        core_video.vsync_n = 1'b1;
        core_rows  = '1;
        core_mic   = 1'b0;
        core_spk   = 1'b0;

        repeat (8) sample_step();
        check_level("core_reset_n", core_reset_n, 1'b0);
        check_level("pixel_ce", pixel_ce, 1'b0);
        check_level("vga.hsync_n", vga.hsync_n, 1'b1);
        check_level("vga.vsync_n", vga.vsync_n, 1'b1);
        check_rgb("vga.rgb", vga.rgb, '0);
        check_columns("core_columns", core_columns, 5'h1F);
        #1;
        rst_n = 1'b1;
        for (int i = 1; i <= 8; i++) begin           // Reset extension
            sample_step();
            check_level("core_reset_n", core_reset_n, i == 8);
            check_level("pixel_ce", pixel_ce, i % 2 == 1);
        end
        repeat (20) begin
            sample_step();
            check_level("core_reset_n", core_reset_n, 1'b1);
        end

        for (int i = 0; i < 16; i++) begin           // Audio and tape pass through
            drive_step();
            core_spk = 1'($urandom());
            core_mic = 1'($urandom());
            ear      = 1'($urandom());
            #1;
            check_level("audio_left", audio_left, core_spk);
            check_level("audio_right", audio_right, core_mic);
            check_level("core_ear", core_ear, ear);
        end

        for (int e = 0; e < 20; e++) begin           // Random presses and releases
            idx = int'($urandom_range(39, 0));
            if (model_keys[idx / 5][idx % 5]) send_byte(8'hF0);
            send_byte(KEY_CODE[idx]);
            sweep_rows();
        end

        if (!model_keys[1][0]) send_byte(8'h1C);     // A held
        if (model_keys[0][1]) begin
            send_byte(8'hF0);                        // Z up
            send_byte(8'h1A);
        end
        send_byte(8'hE0);
        send_byte(8'hF0);
        send_byte(8'h1C);
        send_byte(8'hE0);
        send_byte(8'h1A);
        sweep_rows();
        send_frame(8'h1A, 1'b1);                     // Corrupted Z press
        finish_frame();
        sweep_rows();
        send_byte(8'hF0);
        send_byte(8'h1C);
        sweep_rows();

        send_byte(8'h14);                            // Ctrl
        send_byte(8'h11);                            // Alt
        send_byte(8'hE0);
        send_frame(8'h71, 1'b0);                     // Delete down
        apply_to_model(8'h71);
        t = 0;
        while (core_reset_n !== 1'b0) begin
            if (t == 10) stop_run("core_reset_n stayed high with Ctrl, Alt and Delete held");
            sample_step();
            t++;
        end
        finish_frame();
        send_byte(8'hE0);
        send_byte(8'hF0);
        send_frame(8'h71, 1'b0);                     // Delete up
        apply_to_model(8'h71);
        // Keyboard lets go one cycle after the strobe and 8 extension cycles follow
        for (int i = 1; i <= 9; i++) begin
            sample_step();
            check_level("core_reset_n", core_reset_n, i == 9);
        end
        finish_frame();
        send_byte(8'hF0);
        send_byte(8'h14);
        send_byte(8'hF0);
        send_byte(8'h11);
        sweep_rows();

        for (int n = 0; n < VID_LINES; n++) begin
            line_vs[n] = (n != 3);                   // One line inside vsync
            for (int k = 0; k < LINE_PX; k++) line_px[n][k] = 1'($urandom());
        end
        fork
            drive_video();
            check_video();
        join

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/ace_pkg.sv
rtl/ps2_receiver.sv
rtl/ace_keyboard.sv
rtl/scan_doubler.sv
rtl/ace_board_top.sv
testbench/tb_ace_board.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the board shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_ace_board \
    -f files.f \
    -o sim_ace_board

./obj_dir/sim_ace_board | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
